// File: rtl/interp_pkg.sv
package interp_pkg;

  // ------------------------------
  // Sample widths
  // ------------------------------
  localparam int SAMPLE_W = 8;      // Signed integer reference sample
  localparam int MID_W    = 11;     // After horizontal pass
  localparam int PRED_W   = 14;     // After vertical pass
  localparam int FRAC_W   = 4;      // 16 phases
  localparam int COEF_W   = 8;

  // ------------------------------
  // Block geometry
  // ------------------------------
  localparam int TAPS    = 6;
  localparam int BLK_IN  = 9;
  localparam int BLK_OUT = 4;
  localparam int COL_W   = $clog2(BLK_OUT);

  localparam int H_SHIFT = 4;
  localparam int V_SHIFT = 6;

  // ------------------------------
  // Filter coefficients
  // ------------------------------
  // Each phase sums to 64. Phase 16-p is phase p reversed,
  // so the interpolated point sits between taps 2 and 3.
  localparam logic signed [COEF_W-1:0] filter_coef [16][TAPS] = '{
    '{  0,   0,  64,   0,   0,  0 },    // Identity on tap 2
    '{  1,  -3,  63,   4,  -2,  1 },
    '{  1,  -5,  62,   8,  -3,  1 },
    '{  2,  -8,  60,  13,  -4,  1 },
    '{  2,  -9,  57,  18,  -6,  2 },
    '{  2, -10,  53,  24,  -8,  3 },
    '{  3, -11,  50,  29,  -9,  2 },
    '{  3, -11,  45,  35, -10,  2 },
    '{  3, -11,  40,  40, -11,  3 },    // Half sample
    '{  2, -10,  35,  45, -11,  3 },
    '{  2,  -9,  29,  50, -11,  3 },
    '{  3,  -8,  24,  53, -10,  2 },
    '{  2,  -6,  18,  57,  -9,  2 },
    '{  1,  -4,  13,  60,  -8,  2 },
    '{  1,  -3,   8,  62,  -5,  1 },
    '{  1,  -2,   4,  63,  -3,  1 }
  };

  // ------------------------------
  // Controller
  // ------------------------------
  typedef enum logic [1:0] {
    S_IDLE,
    S_LOAD,       // Accepting input rows
    S_VFILT       // One output column per cycle
  } ctrl_state_t;

endpackage

// File: rtl/fir6_bank.sv
`timescale 1ns/1ps

module fir6_bank import interp_pkg::*; #(
  parameter int IN_W  = SAMPLE_W,
  parameter int OUT_W = MID_W,
  parameter int SHIFT = H_SHIFT,
  parameter bit CLIP  = 1'b1
) (
  input  logic [BLK_IN*IN_W-1:0]   taps_in,     // Sample 0 in the top bits
  input  logic [FRAC_W-1:0]        phase,
  output logic [BLK_OUT*OUT_W-1:0] res          // Result 0 in the top bits
);

  // Six products need three bits of growth
  localparam int ACC_W = IN_W + COEF_W + 3;
  localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'((1 << (OUT_W - 1)) - 1);
  localparam logic signed [ACC_W-1:0] SAT_MIN = ~SAT_MAX;

  logic signed [IN_W-1:0] smp [BLK_IN];

  always_comb begin
    for (int j = 0; j < BLK_IN; j++) begin
      smp[j] = taps_in[(BLK_IN-1-j)*IN_W +: IN_W];
    end
  end

  // ------------------------------
  // One 6-tap filter per output
  // ------------------------------
  for (genvar i = 0; i < BLK_OUT; i++) begin : g_tap
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] shr;
    logic        [OUT_W-1:0] sat;

    always_comb begin
      acc = '0;
      for (int k = 0; k < TAPS; k++) begin
        acc = acc + ACC_W'(smp[i+k]) * ACC_W'(filter_coef[phase][k]);
      end
    end

    assign shr = acc >>> SHIFT;   // Arithmetic, keeps sign

    if (CLIP) begin : g_clip
      always_comb begin
        if (shr > SAT_MAX) begin
          sat = SAT_MAX[OUT_W-1:0];
        end else if (shr < SAT_MIN) begin
          sat = SAT_MIN[OUT_W-1:0];
        end else begin
          sat = shr[OUT_W-1:0];
        end
      end
    end else begin : g_trunc
      assign sat = shr[OUT_W-1:0];  // Range fits by construction
    end

    assign res[(BLK_OUT-1-i)*OUT_W +: OUT_W] = sat;
  end

endmodule

// File: rtl/transpose_buffer.sv
`timescale 1ns/1ps

module transpose_buffer import interp_pkg::*; #(
  parameter int DATA_W = MID_W
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      row_we,
  input  logic [BLK_OUT*DATA_W-1:0] row_in,     // Value 0 in the top bits
  input  logic [COL_W-1:0]          rd_col,
  output logic [BLK_IN*DATA_W-1:0]  col_out     // Oldest row in the top bits
);

  logic [BLK_OUT*DATA_W-1:0] rows [BLK_IN];

  // ------------------------------
  // Row shift store
  // ------------------------------
  // New rows enter at the top index, so rows[0] is the oldest
  // once a full block has been written.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rows <= '{default: '0};
    end else if (row_we) begin
      for (int r = 0; r < BLK_IN - 1; r++) begin
        rows[r] <= rows[r+1];
      end
      rows[BLK_IN-1] <= row_in;
    end
  end

  // ------------------------------
  // Column read
  // ------------------------------
  always_comb begin
    for (int r = 0; r < BLK_IN; r++) begin
      col_out[(BLK_IN-1-r)*DATA_W +: DATA_W] =
        rows[r][(BLK_OUT-1-rd_col)*DATA_W +: DATA_W];
    end
  end

endmodule

// File: rtl/interp_ctrl.sv
`timescale 1ns/1ps

module interp_ctrl import interp_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic [FRAC_W-1:0] frac_x,
  input  logic [FRAC_W-1:0] frac_y,
  input  logic              row_valid,
  output logic              busy,
  output logic              row_ready,
  output logic              row_we,
  output logic [COL_W-1:0]  rd_col,
  output logic [FRAC_W-1:0] phase_h,
  output logic [FRAC_W-1:0] phase_v,
  output logic              out_valid,
  output logic [COL_W-1:0]  out_col
);

  localparam int CNT_W = $clog2(BLK_IN + 1);

  ctrl_state_t      state;
  ctrl_state_t      state_nxt;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_nxt;
  logic             start_ok;
  logic             loop_rows;
  logic             loop_cols;

  // ------------------------------
  // Loop ends and outputs
  // ------------------------------
  assign start_ok  = start && !busy;
  assign loop_rows = (cnt == CNT_W'(BLK_IN - 1));   // 9th row
  assign loop_cols = (cnt == CNT_W'(BLK_OUT - 1));  // 4th column

  assign busy      = (state != S_IDLE);
  assign row_ready = (state == S_LOAD);
  assign row_we    = row_ready && row_valid;
  assign out_valid = (state == S_VFILT);
  assign rd_col    = cnt[COL_W-1:0];
  assign out_col   = cnt[COL_W-1:0];

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt;
    unique case (state)
      S_IDLE: begin
        cnt_nxt = '0;
        if (start_ok) begin
          state_nxt = S_LOAD;
        end
      end
      S_LOAD: begin
        if (row_we) begin
          if (loop_rows) begin
            state_nxt = S_VFILT;
            cnt_nxt   = '0;
          end else begin
            cnt_nxt = cnt + 1'b1;
          end
        end
      end
      S_VFILT: begin
        if (loop_cols) begin
          state_nxt = S_IDLE;
          cnt_nxt   = '0;
        end else begin
          cnt_nxt = cnt + 1'b1;
        end
      end
      default: begin
        state_nxt = S_IDLE;
        cnt_nxt   = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

  // Phases held for the whole block
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_h <= '0;
      phase_v <= '0;
    end else if (start_ok) begin
      phase_h <= frac_x;
      phase_v <= frac_y;
    end
  end

endmodule

// File: rtl/interp_top.sv
`timescale 1ns/1ps

module interp_top import interp_pkg::*; #(
  parameter int PIX_W = SAMPLE_W,
  parameter int INT_W = MID_W,
  parameter int OUT_W = PRED_W,
  parameter int H_SH  = H_SHIFT,
  parameter int V_SH  = V_SHIFT
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  logic [FRAC_W-1:0]       frac_x,
  input  logic [FRAC_W-1:0]       frac_y,
  input  logic                    row_valid,
  input  logic [BLK_IN*PIX_W-1:0] row_data,    // Sample 0 in the top byte
  output logic                    busy,
  output logic                    row_ready,
  output logic                    out_valid,
  output logic [COL_W-1:0]        out_col,
  output logic signed [OUT_W-1:0] pred_0,
  output logic signed [OUT_W-1:0] pred_1,
  output logic signed [OUT_W-1:0] pred_2,
  output logic signed [OUT_W-1:0] pred_3
);

  // ------------------------------
  // Internal wires
  // ------------------------------
  logic                     row_we;
  logic [COL_W-1:0]         rd_col;
  logic [FRAC_W-1:0]        phase_h;
  logic [FRAC_W-1:0]        phase_v;
  logic [BLK_OUT*INT_W-1:0] h_res;
  logic [BLK_IN*INT_W-1:0]  col_data;

  interp_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .frac_x    (frac_x),
    .frac_y    (frac_y),
    .row_valid (row_valid),
    .busy      (busy),
    .row_ready (row_ready),
    .row_we    (row_we),
    .rd_col    (rd_col),
    .phase_h   (phase_h),
    .phase_v   (phase_v),
    .out_valid (out_valid),
    .out_col   (out_col)
  );

  // Horizontal pass, clipped into the buffer width
  fir6_bank #(
    .IN_W  (PIX_W),
    .OUT_W (INT_W),
    .SHIFT (H_SH),
    .CLIP  (1'b1)
  ) h_fir (
    .taps_in (row_data),
    .phase   (phase_h),
    .res     (h_res)
  );

  transpose_buffer #(
    .DATA_W (INT_W)
  ) u_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .row_we  (row_we),
    .row_in  (h_res),
    .rd_col  (rd_col),
    .col_out (col_data)
  );

  fir6_bank #(
    .IN_W  (INT_W),
    .OUT_W (OUT_W),
    .SHIFT (V_SH),
    .CLIP  (1'b0)
  ) v_fir (
    .taps_in (col_data),
    .phase   (phase_v),
    .res     ({pred_0, pred_1, pred_2, pred_3})   // Output rows 0..3
  );

endmodule

// File: test/interp_clk_gen.sv
`timescale 1ns/1ps

module interp_clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;   // Released on a rising edge
  end

endmodule

// File: test/interp_checker.sv
`timescale 1ns/1ps

module interp_checker import interp_pkg::*; (
  input logic             clk,
  input logic             rst_n,
  input logic             busy,
  input logic             row_ready,
  input logic             out_valid,
  input logic [COL_W-1:0] out_col
);

  // ------------------------------
  // Protocol properties
  // ------------------------------
  a_no_out_in_load: assert property (@(posedge clk) disable iff (!rst_n)
    row_ready |-> !out_valid)
    else begin
      $error("out_valid is high while row_ready is high");
      interp_tb.err_cnt++;
    end

  a_col_step: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid ##1 out_valid |-> out_col == COL_W'($past(out_col) + 1'b1))
    else begin
      $error("out_col did not step by one");
      interp_tb.err_cnt++;
    end

  a_busy_out: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> busy)
    else begin
      $error("out_valid is high while busy is low");
      interp_tb.err_cnt++;
    end

  // First edge with reset released
  a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
    else begin
      $error("out_valid is high right after reset release");
      interp_tb.err_cnt++;
    end

endmodule

// File: test/interp_tb.sv
`timescale 1ns/1ps

module interp_tb import interp_pkg::*;;

  localparam int N_BLOCKS  = 18;
  localparam int WD_CYCLES = N_BLOCKS * 40 + 100;
  localparam int H_MAX     = (1 << (MID_W - 1)) - 1;
  localparam int H_MIN     = -(1 << (MID_W - 1));

  logic                       clk;
  logic                       gen_rst_n;
  logic                       soft_rst_n;
  logic                       rst_n;
  logic                       start;
  logic [FRAC_W-1:0]          frac_x;
  logic [FRAC_W-1:0]          frac_y;
  logic                       row_valid;
  logic [BLK_IN*SAMPLE_W-1:0] row_data;
  logic                       busy;
  logic                       row_ready;
  logic                       out_valid;
  logic [COL_W-1:0]           out_col;
  logic signed [PRED_W-1:0]   pred_0;
  logic signed [PRED_W-1:0]   pred_1;
  logic signed [PRED_W-1:0]   pred_2;
  logic signed [PRED_W-1:0]   pred_3;

  logic signed [SAMPLE_W-1:0] cur_blk [BLK_IN][BLK_IN];
  int                         exp_out [BLK_OUT][BLK_OUT];
  int                         cur_fx;
  int                         cur_fy;
  logic [15:0]                lfsr = 16'd14112;
  string                      test_name = "init";
  int                         err_cnt = 0;
  int                         chk_cnt = 0;
  int                         out_seen = 0;
  int                         acc_rows = 0;
  int                         last9 = 0;
  int                         cyc = 0;

  assign rst_n = gen_rst_n && soft_rst_n;   // Mid-block reset from the stimulus

  interp_clk_gen #(.PERIOD(20), .RST_CYCLES(3)) u_clk (.clk(clk), .rst_n(gen_rst_n));

  interp_top DUT (
    .clk(clk), .rst_n(rst_n), .start(start), .frac_x(frac_x), .frac_y(frac_y),
    .row_valid(row_valid), .row_data(row_data), .busy(busy), .row_ready(row_ready),
    .out_valid(out_valid), .out_col(out_col),
    .pred_0(pred_0), .pred_1(pred_1), .pred_2(pred_2), .pred_3(pred_3)
  );

  bind interp_top interp_checker u_chk (
    .clk(clk), .rst_n(rst_n), .busy(busy), .row_ready(row_ready),
    .out_valid(out_valid), .out_col(out_col)
  );

  // ------------------------------
  // Helpers and reference model
  // ------------------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic get_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = (v << 1) | lfsr[0];
    end
  endtask

  task automatic check_val(input string name, input int exp_v, input int act_v);
    chk_cnt++;
    if (exp_v !== act_v) begin
      err_cnt++;
      $display("Error: %s expected %0d actual %0d", name, exp_v, act_v);
    end
  endtask

  function automatic int ref_interp(input int r, input int c);
    int h [TAPS];
    int acc;
    for (int t = 0; t < TAPS; t++) begin
      acc = 0;
      for (int k = 0; k < TAPS; k++) begin
        acc += int'(filter_coef[cur_fx][k]) * int'(cur_blk[r+t][c+k]);
      end
      acc = acc >>> H_SHIFT;
      h[t] = (acc > H_MAX) ? H_MAX : (acc < H_MIN) ? H_MIN : acc;
    end
    acc = 0;
    for (int k = 0; k < TAPS; k++) begin
      acc += int'(filter_coef[cur_fy][k]) * h[k];
    end
    return acc >>> V_SHIFT;
  endfunction

  function automatic logic [BLK_IN*SAMPLE_W-1:0] pack_row(input int r);
    logic [BLK_IN*SAMPLE_W-1:0] d;
    for (int j = 0; j < BLK_IN; j++) begin
      d[(BLK_IN-1-j)*SAMPLE_W +: SAMPLE_W] = cur_blk[r][j];   // Sample 0 on top
    end
    return d;
  endfunction

  task automatic fill_block();
    int v;
    for (int r = 0; r < BLK_IN; r++) begin
      for (int c = 0; c < BLK_IN; c++) begin
        get_bits(SAMPLE_W, v);
        cur_blk[r][c] = v[SAMPLE_W-1:0];
      end
    end
  endtask

  // ------------------------------
  // Block stimulus
  // ------------------------------
  task automatic run_block(input int fx, input int fy, input bit gaps,
                           input bit busy_start, input bit ident);
    int r;
    int v;
    cur_fx = fx;
    cur_fy = fy;
    for (int rr = 0; rr < BLK_OUT; rr++) begin
      for (int cc = 0; cc < BLK_OUT; cc++) begin
        exp_out[rr][cc] = ident ? 4 * int'(cur_blk[rr+2][cc+2]) : ref_interp(rr, cc);
      end
    end
    out_seen = 0;
    @(posedge clk);
    start  <= 1'b1;
    frac_x <= FRAC_W'(fx);
    frac_y <= FRAC_W'(fy);
    r = 0;
    while (r < BLK_IN) begin
      v = 1;
      if (gaps) get_bits(1, v);
      @(posedge clk);
      start <= busy_start;
      if (busy_start) begin
        frac_x <= ~FRAC_W'(fx);   // Must not be captured
        frac_y <= ~FRAC_W'(fy);
      end
      row_valid <= v[0];
      row_data  <= pack_row(r);
      @(negedge clk);
      if (row_valid && row_ready) r++;
    end
    @(posedge clk);
    start     <= 1'b0;
    row_valid <= 1'b0;
    @(negedge clk);
    while (busy) @(negedge clk);
    check_val({test_name, " out_valid count"}, BLK_OUT, out_seen);
  endtask

  task automatic reset_mid_block();
    test_name = "reset_mid_block";
    fill_block();
    @(posedge clk);
    start  <= 1'b1;
    frac_x <= 4'd5;
    frac_y <= 4'd11;
    @(posedge clk);
    start <= 1'b0;
    for (int r = 0; r < 4; r++) begin
      @(posedge clk);
      row_valid <= 1'b1;
      row_data  <= pack_row(r);
    end
    @(posedge clk);
    row_valid  <= 1'b0;
    soft_rst_n <= 1'b0;
    @(negedge clk);
    check_val({test_name, " busy"}, 0, busy);
    check_val({test_name, " row_ready"}, 0, row_ready);
    check_val({test_name, " out_valid"}, 0, out_valid);
    repeat (2) @(posedge clk);
    soft_rst_n <= 1'b1;
  endtask

  // ------------------------------
  // Output comparison
  // ------------------------------
  always @(negedge clk) begin : compare
    int pv [BLK_OUT];
    cyc++;
    if (!rst_n) begin
      acc_rows = 0;
    end else begin
      if (out_valid) begin
        pv[0] = int'(pred_0);
        pv[1] = int'(pred_1);
        pv[2] = int'(pred_2);
        pv[3] = int'(pred_3);
        // Four back-to-back cycles right after the 9th row
        check_val({test_name, " latency"}, last9 + 1 + out_seen, cyc);
        check_val({test_name, " out_col"}, out_seen, int'(out_col));
        for (int r = 0; r < BLK_OUT; r++) begin
          check_val($sformatf("%s pred_%0d col %0d", test_name, r, out_col),
                    exp_out[r][out_col], pv[r]);
        end
        out_seen++;
      end
      if (row_valid && row_ready) begin
        acc_rows++;
        if (acc_rows == BLK_IN) begin
          last9    = cyc;   // Cycle of the 9th acceptance
          acc_rows = 0;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin : stimulus
    int fx;
    int fy;
    start      = 1'b0;
    frac_x     = '0;
    frac_y     = '0;
    row_valid  = 1'b0;
    row_data   = '0;
    soft_rst_n = 1'b1;
    @(posedge gen_rst_n);
    repeat (2) @(posedge clk);

    test_name = "integer_mv";
    fill_block();
    run_block(0, 0, 1'b0, 1'b0, 1'b1);

    test_name = "half_x";
    fill_block();
    run_block(8, 0, 1'b0, 1'b0, 1'b0);

    for (int i = 0; i < 8; i++) begin
      test_name = $sformatf("random_frac_%0d", i);
      get_bits(FRAC_W, fx);
      get_bits(FRAC_W, fy);
      fill_block();
      run_block(fx, fy, 1'b0, 1'b0, 1'b0);
    end

    for (int i = 0; i < 4; i++) begin
      test_name = $sformatf("row_gaps_%0d", i);
      get_bits(FRAC_W, fx);
      get_bits(FRAC_W, fy);
      fill_block();
      run_block(fx, fy, 1'b1, 1'b0, 1'b0);
    end

    for (int i = 0; i < 2; i++) begin
      test_name = $sformatf("start_busy_%0d", i);
      get_bits(FRAC_W, fx);
      get_bits(FRAC_W, fy);
      fill_block();
      run_block(fx, fy, 1'b0, 1'b1, 1'b0);
    end

    reset_mid_block();
    test_name = "after_reset";
    fill_block();
    run_block(3, 13, 1'b0, 1'b0, 1'b0);

    repeat (4) @(posedge clk);
    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: project.f
rtl/interp_pkg.sv
rtl/fir6_bank.sv
rtl/transpose_buffer.sv
rtl/interp_ctrl.sv
rtl/interp_top.sv
test/interp_clk_gen.sv
test/interp_checker.sv
test/interp_tb.sv

// File: Bender.yml
package:
  name: interp

dependencies: {}

sources:
  - files:
      - rtl/interp_pkg.sv
      - rtl/fir6_bank.sv
      - rtl/transpose_buffer.sv
      - rtl/interp_ctrl.sv
      - rtl/interp_top.sv
  - target: test
    files:
      - test/interp_clk_gen.sv
      - test/interp_checker.sv
      - test/interp_tb.sv
